// ==== source/fcta_dm_pkg.sv ====
package fcta_dm_pkg;

    // one data-mover command
    localparam int dm_cmd_w = 72;

    // per-command configuration field ahead of the two mover commands
    localparam int cfg_w = 96;

    // command word as streamed: cfg, then mm2s and s2mm commands
    localparam int cmd_w = cfg_w + 2 * dm_cmd_w;

    // BRAM word, command sits in the low cmd_w bits
    localparam int bram_data_w = 256;

    // data-mover status byte
    localparam int sts_w = 8;

    // error bits of the status byte (internal, decode and slave errors)
    localparam int sts_err_lsb = 4;
    localparam int sts_err_w = 3;

    typedef logic [cmd_w-1:0] cmd_t;

    typedef logic [bram_data_w-1:0] bram_word_t;

    typedef logic [sts_w-1:0] sts_t;

endpackage

// ==== source/fcta_seq_pkg.sv ====
package fcta_seq_pkg;

    // width of all command, item and repeat counters
    localparam int cnt_w = 16;

    // counts and limits, a limit holds its count minus one
    typedef logic [cnt_w-1:0] cnt_t;

    // run state machine
    //   st_idle  waiting for a start edge
    //   st_strm  reading BRAM and streaming commands
    //   st_wait  all commands out, collecting statuses
    typedef enum logic [1:0] {
        st_idle,
        st_strm,
        st_wait
    } seq_state_t;

endpackage

// ==== source/fcta_cmd_fetch.sv ====
`timescale 1ns/1ps

module fcta_cmd_fetch #(
    parameter int bram_addr_w = 10
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    clr,
    input  logic                    fetch_go,
    input  fcta_seq_pkg::cnt_t      num_cmd,
    input  fcta_seq_pkg::cnt_t      num_rpt,
    output logic [bram_addr_w-1:0]  bram_addr,
    output logic                    bram_en,
    input  fcta_dm_pkg::bram_word_t bram_dout,
    output logic                    cmd_tvalid,
    output fcta_dm_pkg::cmd_t       cmd_tdata,
    input  logic                    cmd_tready,
    output logic                    stream_done
);

    import fcta_dm_pkg::*;
    import fcta_seq_pkg::*;

    // read position in the sweep and sweep number
    cnt_t cnt_cmd;
    cnt_t cnt_rpt;

    // reads still to be issued in this run
    logic rd_left;

    // word now in the output slot is the final command of the run
    logic slot_last;

    logic slot_free;
    logic cmd_wrap;
    logic last_rd;

    // slot is free when empty or being taken this cycle
    assign slot_free = !cmd_tvalid || cmd_tready;

    // no read under back-pressure, so the BRAM output holds the command
    assign bram_en = fetch_go && rd_left && slot_free;

    assign cmd_wrap = (cnt_cmd == num_cmd);
    assign last_rd = cmd_wrap && (cnt_rpt == num_rpt);

    assign bram_addr = cnt_cmd[bram_addr_w-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt_cmd <= '0;
            cnt_rpt <= '0;
        end else if (clr) begin
            cnt_cmd <= '0;
            cnt_rpt <= '0;
        end else if (bram_en) begin
            if (cmd_wrap) begin
                cnt_cmd <= '0;
                cnt_rpt <= last_rd ? '0 : cnt_rpt + 1'b1;
            end else begin
                cnt_cmd <= cnt_cmd + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_left <= 1'b0;
        end else if (clr) begin
            rd_left <= 1'b1;
        end else if (bram_en && last_rd) begin
            rd_left <= 1'b0;
        end
    end

    // valid follows each read by one cycle, dropped at once when the run stops
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmd_tvalid <= 1'b0;
            slot_last <= 1'b0;
        end else if (!fetch_go) begin
            cmd_tvalid <= 1'b0;
            slot_last <= 1'b0;
        end else if (bram_en) begin
            cmd_tvalid <= 1'b1;
            slot_last <= last_rd;
        end else if (cmd_tready) begin
            cmd_tvalid <= 1'b0;
            slot_last <= 1'b0;
        end
    end

    assign cmd_tdata = bram_dout[cmd_w-1:0];

    assign stream_done = cmd_tvalid && cmd_tready && slot_last;

    // held command must not change, relies on the BRAM keeping its output
    a_tdata_hold: assert property (@(posedge clk) disable iff (!rstn)
        cmd_tvalid && !cmd_tready |=> $stable(cmd_tdata));

endmodule

// ==== source/fcta_sts_track.sv ====
`timescale 1ns/1ps

module fcta_sts_track (
    input  logic               clk,
    input  logic               rstn,
    input  logic               clr,
    input  logic               sts_en,
    input  fcta_seq_pkg::cnt_t num_item,
    input  fcta_seq_pkg::cnt_t num_rpt,
    input  logic               sts_tvalid,
    input  fcta_dm_pkg::sts_t  sts_tdata,
    output logic               sts_tready,
    output logic               done,
    output logic               err_hit,
    output fcta_dm_pkg::sts_t  last
);

    import fcta_dm_pkg::*;
    import fcta_seq_pkg::*;

    // item inside the current sweep and sweep number
    cnt_t cnt_item;
    cnt_t cnt_rpt;

    logic acc;
    logic item_wrap;
    logic final_item;
    logic sts_bad;

    assign sts_tready = sts_en;
    assign acc = sts_tvalid && sts_tready;

    assign item_wrap = (cnt_item == num_item);
    assign final_item = item_wrap && (cnt_rpt == num_rpt);

    // any error bit set
    assign sts_bad = |sts_tdata[sts_err_lsb +: sts_err_w];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt_item <= '0;
            cnt_rpt <= '0;
        end else if (clr) begin
            cnt_item <= '0;
            cnt_rpt <= '0;
        end else if (acc) begin
            if (item_wrap) begin
                cnt_item <= '0;
                cnt_rpt <= final_item ? '0 : cnt_rpt + 1'b1;
            end else begin
                cnt_item <= cnt_item + 1'b1;
            end
        end
    end

    // sticky until the next run
    always_ff @(posedge clk) begin
        if (!rstn) begin
            done <= 1'b0;
        end else if (clr) begin
            done <= 1'b0;
        end else if (acc && final_item) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_hit <= 1'b0;
        end else begin
            err_hit <= acc && sts_bad;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            last <= sts_tdata;
        end
    end

    // mover must not report more statuses than commands it was given
    a_no_extra_sts: assert property (@(posedge clk) disable iff (!rstn)
        done |-> !acc);

endmodule

// ==== source/fcta_seq_fsm.sv ====
`timescale 1ns/1ps

module fcta_seq_fsm (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic stream_done,
    input  logic mm2s_done,
    input  logic s2mm_done,
    input  logic mm2s_err_hit,
    input  logic s2mm_err_hit,
    output logic clr,
    output logic fetch_go,
    output logic sts_en,
    output logic busy,
    output logic err
);

    import fcta_seq_pkg::*;

    seq_state_t state;

    logic start_q;
    logic start_edge;
    logic abort;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    // start only counts while idle
    assign start_edge = start && !start_q && (state == st_idle);

    assign abort = mm2s_err_hit || s2mm_err_hit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start_edge) begin
                        state <= st_strm;
                    end
                end
                st_strm: begin
                    if (abort) begin
                        state <= st_idle;
                    end else if (stream_done) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // an error ends the run as well
                    if (abort || (mm2s_done && s2mm_done)) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            err <= 1'b0;
        end else if (clr) begin
            err <= 1'b0;
        end else if (abort) begin
            err <= 1'b1;
        end
    end

    assign clr = start_edge;

    // fetching stops in the error cycle itself so no command follows err
    assign fetch_go = (state == st_strm) && !abort;
    assign sts_en = (state == st_strm) || (state == st_wait);
    assign busy = (state != st_idle);

    a_go_not_idle: assert property (@(posedge clk) disable iff (!rstn)
        !(fetch_go && state == st_idle));

endmodule

// ==== source/fcta_ctl.sv ====
`timescale 1ns/1ps

module fcta_ctl #(
    parameter int bram_addr_w = 10
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,

    // run shape, each a count minus one
    input  fcta_seq_pkg::cnt_t      num_cmd,
    input  fcta_seq_pkg::cnt_t      num_cmd_s2mm,
    input  fcta_seq_pkg::cnt_t      num_rpt,

    // read-only command BRAM
    output logic [bram_addr_w-1:0]  bram_addr,
    output logic                    bram_en,
    input  fcta_dm_pkg::bram_word_t bram_dout,

    // command stream
    output logic                    cmd_tvalid,
    output fcta_dm_pkg::cmd_t       cmd_tdata,
    input  logic                    cmd_tready,

    // status streams
    input  logic                    mm2s_sts_tvalid,
    input  fcta_dm_pkg::sts_t       mm2s_sts_tdata,
    output logic                    mm2s_sts_tready,
    input  logic                    s2mm_sts_tvalid,
    input  fcta_dm_pkg::sts_t       s2mm_sts_tdata,
    output logic                    s2mm_sts_tready,

    output fcta_dm_pkg::sts_t       mm2s_sts_last,
    output fcta_dm_pkg::sts_t       s2mm_sts_last,
    output logic                    busy,
    output logic                    err
);

    logic clr;
    logic fetch_go;
    logic sts_en;
    logic stream_done;
    logic mm2s_done;
    logic s2mm_done;
    logic mm2s_err_hit;
    logic s2mm_err_hit;

    fcta_seq_fsm fsm_i (
        .clk          (clk),
        .rstn         (rstn),
        .start        (start),
        .stream_done  (stream_done),
        .mm2s_done    (mm2s_done),
        .s2mm_done    (s2mm_done),
        .mm2s_err_hit (mm2s_err_hit),
        .s2mm_err_hit (s2mm_err_hit),
        .clr          (clr),
        .fetch_go     (fetch_go),
        .sts_en       (sts_en),
        .busy         (busy),
        .err          (err)
    );

    fcta_cmd_fetch #(
        .bram_addr_w (bram_addr_w)
    ) fetch_i (
        .clk         (clk),
        .rstn        (rstn),
        .clr         (clr),
        .fetch_go    (fetch_go),
        .num_cmd     (num_cmd),
        .num_rpt     (num_rpt),
        .bram_addr   (bram_addr),
        .bram_en     (bram_en),
        .bram_dout   (bram_dout),
        .cmd_tvalid  (cmd_tvalid),
        .cmd_tdata   (cmd_tdata),
        .cmd_tready  (cmd_tready),
        .stream_done (stream_done)
    );

    // one status per command per sweep
    fcta_sts_track mm2s_trk_i (
        .clk        (clk),
        .rstn       (rstn),
        .clr        (clr),
        .sts_en     (sts_en),
        .num_item   (num_cmd),
        .num_rpt    (num_rpt),
        .sts_tvalid (mm2s_sts_tvalid),
        .sts_tdata  (mm2s_sts_tdata),
        .sts_tready (mm2s_sts_tready),
        .done       (mm2s_done),
        .err_hit    (mm2s_err_hit),
        .last       (mm2s_sts_last)
    );

    // s2mm runs its own count per sweep
    fcta_sts_track s2mm_trk_i (
        .clk        (clk),
        .rstn       (rstn),
        .clr        (clr),
        .sts_en     (sts_en),
        .num_item   (num_cmd_s2mm),
        .num_rpt    (num_rpt),
        .sts_tvalid (s2mm_sts_tvalid),
        .sts_tdata  (s2mm_sts_tdata),
        .sts_tready (s2mm_sts_tready),
        .done       (s2mm_done),
        .err_hit    (s2mm_err_hit),
        .last       (s2mm_sts_last)
    );

endmodule

// ==== test/fcta_bram_model.sv ====
`timescale 1ns/1ps

module fcta_bram_model #(
    parameter int addr_w = 10
) (
    input  logic                    clk,
    input  logic                    en,
    input  logic [addr_w-1:0]       addr,
    output fcta_dm_pkg::bram_word_t dout
);

    import fcta_dm_pkg::*;

    // every 16-bit lane holds the address plus 16'h1000
    function automatic bram_word_t word_at(logic [addr_w-1:0] a);
        bram_word_t w;
        for (int i = 0; i < bram_data_w / 16; i++) begin
            w[i*16 +: 16] = 16'(a) + 16'h1000;
        end
        return w;
    endfunction

    // one cycle read latency, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            dout <= word_at(addr);
        end
    end

endmodule

// ==== test/fcta_ctl_tb.sv ====
`timescale 1ns/1ps

module fcta_ctl_tb;

    import fcta_dm_pkg::*;
    import fcta_seq_pkg::*;

    localparam int bram_addr_w = 10;
    localparam int tmo = 5000;
    localparam int no_err = 'hffff;

    logic clk;
    logic rstn = 1'b0;
    logic start = 1'b0;
    cnt_t num_cmd = '0;
    cnt_t num_cmd_s2mm = '0;
    cnt_t num_rpt = '0;
    logic [bram_addr_w-1:0] bram_addr;
    logic bram_en;
    bram_word_t bram_dout;
    logic cmd_tvalid;
    cmd_t cmd_tdata;
    logic cmd_tready = 1'b0;
    logic mm2s_sts_tvalid = 1'b0;
    sts_t mm2s_sts_tdata = '0;
    logic mm2s_sts_tready;
    logic s2mm_sts_tvalid = 1'b0;
    sts_t s2mm_sts_tdata = '0;
    logic s2mm_sts_tready;
    sts_t mm2s_sts_last;
    sts_t s2mm_sts_last;
    logic busy;
    logic err;

    // five words per scenario, see the trace file
    logic [15:0] trace_mem [0:79];
    integer seed = 32'hf9d4;
    int mism_cnt = 0;
    int fail_cnt = 0;
    int cmd_cnt = 0;
    int mm2s_sent = 0;
    int s2mm_sent = 0;
    int s2mm_shown = -1;
    int cmd_total = 0;
    int s2mm_total = 0;
    int tready_pct = 0;
    int err_idx = no_err;
    logic run_act = 1'b0;
    logic err_sent = 1'b0;
    logic hold_q = 1'b0;
    cmd_t hold_data;
    sts_t mm2s_lastb;
    sts_t s2mm_lastb;

    fcta_ctl #(.bram_addr_w(bram_addr_w)) dut_i (.*);

    fcta_bram_model #(.addr_w(bram_addr_w)) bram_i (
        .clk  (clk),
        .en   (bram_en),
        .addr (bram_addr),
        .dout (bram_dout)
    );

    // command word the BRAM pattern gives at address a
    function automatic cmd_t exp_cmd(int a);
        bram_word_t w;
        for (int i = 0; i < bram_data_w / 16; i++) begin
            w[i*16 +: 16] = 16'(a) + 16'h1000;
        end
        return w[cmd_w-1:0];
    endfunction

    // okay bit 7, tag in the low nibble, bit 5 as injected error
    function automatic sts_t sts_byte(int idx, logic bad);
        return {1'b1, 1'b0, bad, 1'b0, 4'(idx)};
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // sample handshakes on the rising edge
    always @(posedge clk) begin
        if (start) begin
            cmd_cnt = 0;
            mm2s_sent = 0;
            s2mm_sent = 0;
            err_sent = 1'b0;
        end
        if (hold_q && !err) begin
            assert (cmd_tvalid && cmd_tdata == hold_data) else begin
                mism_cnt++;
                $display("MISMATCH at %0t: held command changed or withdrawn", $time);
            end
        end
        hold_q = cmd_tvalid && !cmd_tready;
        hold_data = cmd_tdata;
        if (cmd_tvalid && cmd_tready) begin
            assert (!err && cmd_cnt < cmd_total) else begin
                fail_cnt++;
                $display("ERROR at %0t: command accepted after the run ended", $time);
            end
            assert (cmd_tdata == exp_cmd(cmd_cnt % (int'(num_cmd) + 1))) else begin
                mism_cnt++;
                $display("MISMATCH at %0t: command %0d has wrong data", $time, cmd_cnt);
            end
            cmd_cnt++;
        end
        if (mm2s_sts_tvalid && mm2s_sts_tready) begin
            mm2s_lastb = mm2s_sts_tdata;
            err_sent = err_sent || mm2s_sts_tdata[5];
            mm2s_sent++;
        end
        if (s2mm_sts_tvalid && s2mm_sts_tready) begin
            s2mm_lastb = s2mm_sts_tdata;
            s2mm_sent++;
        end
    end

    // ready and status responders, driven on the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            cmd_tready = ($unsigned($random(seed)) % 100) < tready_pct;
            // mm2s answers each accepted command in order
            mm2s_sts_tvalid = run_act && !err_sent && mm2s_sent < cmd_cnt;
            mm2s_sts_tdata = sts_byte(mm2s_sent, mm2s_sent == err_idx);
            if (!(run_act && s2mm_sts_tvalid && s2mm_sent == s2mm_shown)) begin
                s2mm_sts_tvalid = run_act && s2mm_sent < s2mm_total
                                  && $random(seed) % 2 == 0;
                s2mm_sts_tdata = sts_byte(s2mm_sent + 8, 1'b0);
                s2mm_shown = s2mm_sent;
            end
        end
    end

    task automatic run_scenario(input cnt_t nc, input cnt_t ns, input cnt_t nr,
                                input int pct, input int eidx);
        int t;
        @(negedge clk);
        num_cmd = nc;
        num_cmd_s2mm = ns;
        num_rpt = nr;
        tready_pct = pct;
        err_idx = eidx;
        cmd_total = (int'(nc) + 1) * (int'(nr) + 1);
        s2mm_total = (int'(ns) + 1) * (int'(nr) + 1);
        run_act = 1'b1;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else begin
            mism_cnt++;
            $display("MISMATCH at %0t: busy did not rise after start", $time);
        end
        t = 0;
        while (busy && t < tmo) begin
            @(negedge clk);
            t++;
        end
        assert (t < tmo) else begin
            fail_cnt++;
            $display("ERROR at %0t: timed out waiting for the run to end", $time);
        end
        run_act = 1'b0;
        if (eidx != no_err) begin
            assert (err && err_sent) else begin
                mism_cnt++;
                $display("MISMATCH at %0t: injected status error not flagged", $time);
            end
        end else begin
            assert (!err && cmd_cnt == cmd_total && mm2s_sent == cmd_total
                    && s2mm_sent == s2mm_total) else begin
                mism_cnt++;
                $display("MISMATCH at %0t: err %0b cmd %0d/%0d mm2s %0d s2mm %0d/%0d",
                         $time, err, cmd_cnt, cmd_total, mm2s_sent, s2mm_sent, s2mm_total);
            end
            assert (mm2s_sts_last == mm2s_lastb && s2mm_sts_last == s2mm_lastb) else begin
                mism_cnt++;
                $display("MISMATCH at %0t: last status bytes %h %h, sent %h %h", $time,
                         mm2s_sts_last, s2mm_sts_last, mm2s_lastb, s2mm_lastb);
            end
        end
        // idle gap, any late command is caught by the monitor
        repeat (10) @(negedge clk);
        assert (!cmd_tvalid && !busy) else begin
            mism_cnt++;
            $display("MISMATCH at %0t: command or busy still active when idle", $time);
        end
    endtask

    initial begin
        int base;
        for (int i = 0; i < 80; i++) begin
            trace_mem[i] = 16'hffff;
        end
        $readmemh("test/fcta_ctl_trace.txt", trace_mem);
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        assert (!cmd_tvalid && !bram_en && !mm2s_sts_tready && !s2mm_sts_tready
                && !busy && !err) else begin
            mism_cnt++;
            $display("MISMATCH at %0t: outputs not low after reset", $time);
        end
        assert (trace_mem[0] != 16'hffff) else begin
            fail_cnt++;
            $display("ERROR: trace file gave no scenario");
        end
        for (int s = 0; s < 16 && trace_mem[s*5] != 16'hffff; s++) begin
            base = s * 5;
            run_scenario(trace_mem[base], trace_mem[base+1], trace_mem[base+2],
                         int'(trace_mem[base+3]), int'(trace_mem[base+4]));
            // same shape again without the error, err must clear
            if (int'(trace_mem[base+4]) != no_err) begin
                run_scenario(trace_mem[base], trace_mem[base+1], trace_mem[base+2],
                             int'(trace_mem[base+3]), no_err);
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== test/fcta_ctl_trace.txt ====
// columns in hex: num_cmd num_cmd_s2mm num_rpt tready_pct err_idx
// err_idx counts mm2s statuses, ffff means no injected error
0000 0000 0000 0064 ffff
0003 0001 0001 0064 ffff
0007 0004 0002 001e ffff
0002 0005 0003 0032 ffff
0005 0005 0001 0046 0004
0004 0000 0002 0028 0009
000f 0002 0000 005a ffff
0001 0003 0004 0050 0000

// ==== fcta_ctl.f ====
source/fcta_dm_pkg.sv
source/fcta_seq_pkg.sv
source/fcta_cmd_fetch.sv
source/fcta_sts_track.sv
source/fcta_seq_fsm.sv
source/fcta_ctl.sv
test/fcta_bram_model.sv
test/fcta_ctl_tb.sv

// ==== Makefile ====
# Verilator build and simulation of the command sequencer

.PHONY: run lint clean

run:
	verilator --binary --assert --timescale 1ns/1ps --top-module fcta_ctl_tb \
		-f fcta_ctl.f -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q ">>> PASS" sim.log
	! grep -q ">>> FAIL" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module fcta_ctl -f fcta_ctl.f

clean:
	rm -rf obj_dir sim.log
